// File: fetch_bus_pkg.sv
`include "fetch_cfg.svh"

package fetch_bus_pkg;

  // Field positions inside a fetch address
  localparam int OFF_LSB = 2;
  localparam int IDX_LSB = OFF_LSB + `FETCH_LINE_LOG2;
  localparam int TAG_LSB = IDX_LSB + `FETCH_SETS_LOG2;

  typedef logic [31-TAG_LSB:0]            tag_t;
  typedef logic [`FETCH_SETS_LOG2-1:0]    index_t;
  typedef logic [`FETCH_LINE_LOG2-1:0]    offset_t;

  // Line refill sequence, even word first
  typedef enum logic [2:0] {
    RF_IDLE      = 3'd0,
    RF_WAIT_EVEN = 3'd1,
    RF_REQ_ODD   = 3'd2,
    RF_WAIT_ODD  = 3'd3,
    RF_DONE      = 3'd4
  } refill_state_e;

  typedef struct packed {
    fetch_inst_pkg::pc_t addr;
    logic                valid;
  } rd_req_t;

  typedef struct packed {
    fetch_inst_pkg::inst_t data;
    logic                  valid;
  } rd_rsp_t;

endpackage

// File: fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// Cache geometry as log2 values for 4 sets of 2 words
`define FETCH_SETS_LOG2 2
`define FETCH_LINE_LOG2 1

// Opcodes that end sequential fetch
`define FETCH_OP_JAL    7'b1101111
`define FETCH_OP_JALR   7'b1100111
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_SYSTEM 7'b1110011
`define FETCH_OP_LOAD   7'b0000011

`define FETCH_INST_FENCE_I 32'h0000_100f

`endif

// File: fetch_input.mem
// @00 memory image from FETCH_RESET_PC, @40 item count, redirect count, final bus request count
// @48 bus request count before redirect and redirect target, @60 expected pc and instruction pairs
@00
00100093 00200113
00300193 0000a203
00500293 fe000ee3
0000100f 00600313
00700393 00008067
00800413 00000073
@40
00000014 00000007 00000014
@48
00000004 80000010
00000006 80000010
00000006 80000018
00000008 80000010
0000000a 8000001c
0000000e 80000000
00000012 80000028
@60
80000000 00100093 80000004 00200113
80000008 00300193 8000000c 0000a203
80000010 00500293 80000014 fe000ee3
80000010 00500293 80000014 fe000ee3
80000018 0000100f 80000010 00500293
80000014 fe000ee3 8000001c 00600313
80000020 00700393 80000024 00008067
80000000 00100093 80000004 00200113
80000008 00300193 8000000c 0000a203
80000028 00800413 8000002c 00000073

// File: fetch_inst_pkg.sv
package fetch_inst_pkg;

  // Byte address of an instruction
  typedef logic [31:0] pc_t;

  // Raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  // What fetch must do after issuing the instruction
  typedef enum logic [1:0] {
    KIND_SEQ     = 2'd0,
    KIND_CTRL    = 2'd1,
    KIND_LOAD    = 2'd2,
    KIND_FENCE_I = 2'd3
  } inst_kind_e;

  // Item handed to decode
  typedef struct packed {
    pc_t        pc;
    inst_t      inst;
    inst_kind_e kind;
  } fetch_item_t;

endpackage

// File: fetch_unit.f
+incdir+.
fetch_inst_pkg.sv
fetch_bus_pkg.sv
pc_stage.sv
l1i_cache.sv
inst_classify.sv
fetch_unit.sv
tb_inst_mem.sv
fetch_unit_tb.sv

// File: fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
  input  logic                        clk,
  input  logic                        rst,
  output fetch_bus_pkg::rd_req_t      bus_req_o,
  input  fetch_bus_pkg::rd_rsp_t      bus_rsp_i,
  output fetch_inst_pkg::fetch_item_t item_o,
  output logic                        valid_o,
  input  logic                        ready_i,
  input  logic                        redirect_i,
  input  fetch_inst_pkg::pc_t         redirect_pc_i
);

  fetch_inst_pkg::pc_t   fetch_pc;
  logic                  fetch_req;
  logic                  hit;
  fetch_inst_pkg::inst_t hit_inst;
  logic                  take;
  logic                  stop;
  logic                  flush;

  pc_stage pc_stage_inst (
    .clk           (clk),
    .rst           (rst),
    .take_i        (take),
    .stop_i        (stop),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_pc_o    (fetch_pc),
    .fetch_req_o   (fetch_req)
  );

  l1i_cache l1i_cache_inst (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc_i  (fetch_pc),
    .fetch_req_i (fetch_req),
    .flush_i     (flush),
    .hit_o       (hit),
    .hit_inst_o  (hit_inst),
    .bus_req_o   (bus_req_o),
    .bus_rsp_i   (bus_rsp_i)
  );

  inst_classify inst_classify_inst (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc_i  (fetch_pc),
    .fetch_req_i (fetch_req),
    .hit_i       (hit),
    .hit_inst_i  (hit_inst),
    .take_o      (take),
    .stop_o      (stop),
    .flush_o     (flush),
    .item_o      (item_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i)
  );

endmodule

// File: fetch_unit_tb.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module fetch_unit_tb;

  localparam int HDR_AT   = 'h40;
  localparam int REDIR_AT = 'h48;
  localparam int EXP_AT   = 'h60;

  logic                        clk;
  logic                        rst;
  fetch_bus_pkg::rd_req_t      bus_req;
  fetch_bus_pkg::rd_rsp_t      bus_rsp;
  fetch_inst_pkg::fetch_item_t item;
  logic                        valid;
  logic                        ready;
  logic                        redirect;
  fetch_inst_pkg::pc_t         redirect_pc;
  int                          req_count;

  logic [31:0]                 file_words [0:255];
  integer                      seed;
  int                          n_items;
  int                          n_redirects;
  int                          item_idx;
  int                          redirect_idx;
  int                          cycle_count;
  int                          cycle_limit;
  logic                        wait_redirect;
  logic                        first_after;
  logic                        stall;
  fetch_inst_pkg::fetch_item_t held_item;
  fetch_inst_pkg::pc_t         last_pc;
  fetch_inst_pkg::pc_t         exp_pc;
  fetch_inst_pkg::inst_t       exp_inst;
  fetch_inst_pkg::inst_kind_e  exp_kind;

  fetch_unit fetch_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .bus_req_o     (bus_req),
    .bus_rsp_i     (bus_rsp),
    .item_o        (item),
    .valid_o       (valid),
    .ready_i       (ready),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc)
  );

  tb_inst_mem tb_inst_mem_inst (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .req_count_o (req_count)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Kind follows the opcode unless the word is the full FENCE.I encoding
  function automatic fetch_inst_pkg::inst_kind_e kind_of_inst(input logic [31:0] inst);
    fetch_inst_pkg::inst_kind_e kind;
    if (inst == `FETCH_INST_FENCE_I) begin
      kind = fetch_inst_pkg::KIND_FENCE_I;
    end else if (inst[6:0] == `FETCH_OP_JAL || inst[6:0] == `FETCH_OP_JALR ||
                 inst[6:0] == `FETCH_OP_BRANCH || inst[6:0] == `FETCH_OP_SYSTEM) begin
      kind = fetch_inst_pkg::KIND_CTRL;
    end else if (inst[6:0] == `FETCH_OP_LOAD) begin
      kind = fetch_inst_pkg::KIND_LOAD;
    end else begin
      kind = fetch_inst_pkg::KIND_SEQ;
    end
    return kind;
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_problem(input string why);
    $display("Error at %0t ns: %s", $time, why);
    stop_with_failure();
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    assert (cycle_count <= cycle_limit)
      else report_problem("timeout, the expected items did not all arrive");
  end

  initial begin
    seed          = 32'h846f5aa8;
    rst           = 1'b1;
    ready         = 1'b0;
    redirect      = 1'b0;
    redirect_pc   = '0;
    cycle_count   = 0;
    item_idx      = 0;
    redirect_idx  = 0;
    wait_redirect = 1'b0;
    first_after   = 1'b0;
    stall         = 1'b0;
    held_item     = '0;
    last_pc       = '0;
    $readmemh("fetch_input.mem", file_words);
    n_items     = file_words[HDR_AT];
    n_redirects = file_words[HDR_AT + 1];
    cycle_limit = 200 * n_items;
    assert (n_items > 0) else report_problem("memory file holds no expected items");

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;

    while (item_idx < n_items) begin
      // A stalled item must not move
      if (stall) begin
        assert (valid == 1'b1) else report_mismatch("valid_o", 1, valid);
        assert (item == held_item) else report_mismatch("item_o", held_item, item);
      end
      redirect = 1'b0;
      if (wait_redirect) begin
        assert (valid == 1'b0) else report_mismatch("valid_o", 0, valid);
        assert (req_count == file_words[REDIR_AT + 2 * redirect_idx])
          else report_mismatch("req_count", file_words[REDIR_AT + 2 * redirect_idx], req_count);
        redirect      = 1'b1;
        redirect_pc   = file_words[REDIR_AT + 2 * redirect_idx + 1];
        redirect_idx  = redirect_idx + 1;
        wait_redirect = 1'b0;
        first_after   = 1'b1;
      end
      ready = (($random(seed) & 3) != 0);
      if (valid && ready) begin
        exp_pc   = file_words[EXP_AT + 2 * item_idx];
        exp_inst = file_words[EXP_AT + 2 * item_idx + 1];
        exp_kind = kind_of_inst(exp_inst);
        assert (item.pc == exp_pc) else report_mismatch("item_o.pc", exp_pc, item.pc);
        assert (item.inst == exp_inst) else report_mismatch("item_o.inst", exp_inst, item.inst);
        assert (item.kind == exp_kind) else report_mismatch("item_o.kind", exp_kind, item.kind);
        if (first_after) begin
          assert (item.pc == redirect_pc) else report_mismatch("item_o.pc", redirect_pc, item.pc);
        end else if (item_idx > 0) begin
          assert (item.pc == last_pc + 32'd4)
            else report_mismatch("item_o.pc", last_pc + 32'd4, item.pc);
        end
        first_after = 1'b0;
        last_pc     = item.pc;
        item_idx    = item_idx + 1;
        if (exp_kind != fetch_inst_pkg::KIND_SEQ && item_idx < n_items) begin
          assert (redirect_idx < n_redirects)
            else report_problem("redirect list ran out before the expected items");
          wait_redirect = 1'b1;
        end
      end
      stall     = valid && !ready;
      held_item = item;
      @(negedge clk);
    end

    // Fetch is stopped on the last item, so the bus is idle here
    assert (valid == 1'b0) else report_mismatch("valid_o", 0, valid);
    assert (req_count == file_words[HDR_AT + 2])
      else report_mismatch("req_count", file_words[HDR_AT + 2], req_count);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: inst_classify.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module inst_classify (
  input  logic                        clk,
  input  logic                        rst,
  input  fetch_inst_pkg::pc_t         fetch_pc_i,
  input  logic                        fetch_req_i,
  input  logic                        hit_i,
  input  fetch_inst_pkg::inst_t       hit_inst_i,
  output logic                        take_o,
  output logic                        stop_o,
  output logic                        flush_o,
  output fetch_inst_pkg::fetch_item_t item_o,
  output logic                        valid_o,
  input  logic                        ready_i
);

  fetch_inst_pkg::inst_kind_e  kind;
  fetch_inst_pkg::fetch_item_t item_q;
  logic                        valid_q;
  logic                        stage_ready;
  logic [6:0]                  opcode;

  assign opcode = hit_inst_i[6:0];

  // FENCE.I must match in full, other kinds go by opcode
  always_comb begin
    if (hit_inst_i == `FETCH_INST_FENCE_I) begin
      kind = fetch_inst_pkg::KIND_FENCE_I;
    end else begin
      case (opcode)
        `FETCH_OP_JAL,
        `FETCH_OP_JALR,
        `FETCH_OP_BRANCH,
        `FETCH_OP_SYSTEM: kind = fetch_inst_pkg::KIND_CTRL;
        `FETCH_OP_LOAD:   kind = fetch_inst_pkg::KIND_LOAD;
        default:          kind = fetch_inst_pkg::KIND_SEQ;
      endcase
    end
  end

  // Register is free when empty or drained this cycle
  assign stage_ready = !valid_q || ready_i;
  assign take_o      = fetch_req_i && hit_i && stage_ready;
  assign stop_o      = take_o && (kind != fetch_inst_pkg::KIND_SEQ);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (take_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_o) begin
      item_q.pc   <= fetch_pc_i;
      item_q.inst <= hit_inst_i;
      item_q.kind <= kind;
    end
  end

  assign flush_o = valid_q && ready_i && (item_q.kind == fetch_inst_pkg::KIND_FENCE_I);
  assign item_o  = item_q;
  assign valid_o = valid_q;

endmodule

// File: l1i_cache.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module l1i_cache (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_inst_pkg::pc_t    fetch_pc_i,
  input  logic                   fetch_req_i,
  input  logic                   flush_i,
  output logic                   hit_o,
  output fetch_inst_pkg::inst_t  hit_inst_o,
  output fetch_bus_pkg::rd_req_t bus_req_o,
  input  fetch_bus_pkg::rd_rsp_t bus_rsp_i
);

  localparam int SETS  = 1 << `FETCH_SETS_LOG2;
  localparam int WORDS = 1 << `FETCH_LINE_LOG2;

  fetch_inst_pkg::inst_t        line_data [SETS][WORDS];
  fetch_bus_pkg::tag_t          line_tag  [SETS];
  logic [SETS-1:0]              line_valid_q;

  fetch_bus_pkg::refill_state_e state_q;
  fetch_bus_pkg::refill_state_e state_d;

  fetch_bus_pkg::tag_t          addr_tag;
  fetch_bus_pkg::index_t        addr_idx;
  fetch_bus_pkg::offset_t       addr_off;
  fetch_bus_pkg::offset_t       word_sel;
  logic                         miss;

  assign addr_tag = fetch_pc_i[31:fetch_bus_pkg::TAG_LSB];
  assign addr_idx = fetch_pc_i[fetch_bus_pkg::TAG_LSB-1:fetch_bus_pkg::IDX_LSB];
  assign addr_off = fetch_pc_i[fetch_bus_pkg::IDX_LSB-1:fetch_bus_pkg::OFF_LSB];

  assign hit_o      = line_valid_q[addr_idx] && (line_tag[addr_idx] == addr_tag);
  assign hit_inst_o = line_data[addr_idx][addr_off];
  assign miss       = fetch_req_i && !hit_o;

  // Even word goes out first, odd word after the gap cycle
  always_comb begin
    state_d         = state_q;
    word_sel        = fetch_bus_pkg::offset_t'(0);
    bus_req_o.valid = 1'b0;
    case (state_q)
      fetch_bus_pkg::RF_IDLE: begin
        if (miss) begin
          bus_req_o.valid = 1'b1;
          state_d         = fetch_bus_pkg::RF_WAIT_EVEN;
        end
      end
      fetch_bus_pkg::RF_WAIT_EVEN: begin
        bus_req_o.valid = 1'b1;
        if (bus_rsp_i.valid) begin
          state_d = fetch_bus_pkg::RF_REQ_ODD;
        end
      end
      fetch_bus_pkg::RF_REQ_ODD: begin
        word_sel = fetch_bus_pkg::offset_t'(1);
        state_d  = fetch_bus_pkg::RF_WAIT_ODD;
      end
      fetch_bus_pkg::RF_WAIT_ODD: begin
        word_sel        = fetch_bus_pkg::offset_t'(1);
        bus_req_o.valid = 1'b1;
        if (bus_rsp_i.valid) begin
          state_d = fetch_bus_pkg::RF_DONE;
        end
      end
      fetch_bus_pkg::RF_DONE: begin
        state_d = fetch_bus_pkg::RF_IDLE;
      end
      default: begin
        state_d = fetch_bus_pkg::RF_IDLE;
      end
    endcase
    bus_req_o.addr = {fetch_pc_i[31:fetch_bus_pkg::IDX_LSB], word_sel, 2'b00};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_bus_pkg::RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Old contents of the set are dropped as soon as its refill starts
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid_q <= '0;
    end else if (flush_i) begin
      line_valid_q <= '0;
    end else if (state_q == fetch_bus_pkg::RF_IDLE && miss) begin
      line_valid_q[addr_idx] <= 1'b0;
    end else if (state_q == fetch_bus_pkg::RF_DONE) begin
      line_valid_q[addr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == fetch_bus_pkg::RF_WAIT_EVEN && bus_rsp_i.valid) begin
      line_data[addr_idx][fetch_bus_pkg::offset_t'(0)] <= bus_rsp_i.data;
      line_tag[addr_idx]                               <= addr_tag;
    end
    if (state_q == fetch_bus_pkg::RF_WAIT_ODD && bus_rsp_i.valid) begin
      line_data[addr_idx][fetch_bus_pkg::offset_t'(1)] <= bus_rsp_i.data;
    end
  end

endmodule

// File: pc_stage.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module pc_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                take_i,
  input  logic                stop_i,
  input  logic                redirect_i,
  input  fetch_inst_pkg::pc_t redirect_pc_i,
  output fetch_inst_pkg::pc_t fetch_pc_o,
  output logic                fetch_req_o
);

  fetch_inst_pkg::pc_t pc_q;
  logic                stopped_q;

  // Stopped flag waits for a redirect after a non-sequential instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      stopped_q <= 1'b0;
    end else if (stopped_q && redirect_i) begin
      stopped_q <= 1'b0;
    end else if (take_i && stop_i) begin
      stopped_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (stopped_q && redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (take_i && !stop_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Redirects arriving while fetch is running are ignored

  assign fetch_pc_o  = pc_q;
  assign fetch_req_o = !stopped_q;

endmodule

// File: tb_inst_mem.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module tb_inst_mem (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_bus_pkg::rd_req_t bus_req_i,
  output fetch_bus_pkg::rd_rsp_t bus_rsp_o,
  output int                     req_count_o
);

  logic [31:0]         words [0:255];
  fetch_inst_pkg::pc_t addr_q;
  logic                busy_q;
  int                  wait_q;
  integer              seed;

  initial begin
    seed        = 32'h846f5aa8;
    bus_rsp_o   = '0;
    req_count_o = 0;
    busy_q      = 1'b0;
    wait_q      = 0;
    addr_q      = '0;
    // Words outside the image read back as the inverted address
    for (int i = 0; i < 256; i++) begin
      words[i] = ~(`FETCH_RESET_PC + 32'(4 * i));
    end
    $readmemh("fetch_input.mem", words);
  end

  // One read at a time, answered with a single-cycle valid pulse
  always @(negedge clk) begin
    if (rst) begin
      bus_rsp_o   <= '0;
      busy_q      <= 1'b0;
      wait_q      <= 0;
      req_count_o <= 0;
    end else if (bus_rsp_o.valid) begin
      bus_rsp_o.valid <= 1'b0;
    end else if (busy_q) begin
      if (wait_q == 0) begin
        bus_rsp_o.valid <= 1'b1;
        bus_rsp_o.data  <= words[((addr_q - `FETCH_RESET_PC) >> 2) & 32'd255];
        busy_q          <= 1'b0;
      end else begin
        wait_q <= wait_q - 1;
      end
    end else if (bus_req_i.valid) begin
      addr_q      <= bus_req_i.addr;
      busy_q      <= 1'b1;
      wait_q      <= $random(seed) & 3;
      req_count_o <= req_count_o + 1;
    end
  end

endmodule
